// File: flist.f
verilog/barrel_pkg.sv
verilog/thread_pc.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_write.sv
verilog/barrel_core.sv
testbench/clock_gen.sv
testbench/barrel_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module barrel_core_tb -f flist.f -o barrel_core_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/barrel_core_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: testbench/barrel_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_core_tb
    import barrel_pkg::*;
;

    localparam int WORD_WIDTH        = 16;
    localparam int THREAD_COUNT      = 4;
    localparam int THREAD_ADDR_WIDTH = 2;
    localparam int I_DEPTH           = 64;
    localparam int REGION            = I_DEPTH / THREAD_COUNT;
    localparam int PERIOD_NS         = 40;
    localparam int DRAIN_CYCLES      = 8;

    // instructions each test runs, weighted by the round-robin slot and a factor of two.
    localparam int TEST_INSTRS   = 1 + 10 + 18 + 28 + 3;
    localparam int RUN_CYCLES    = TEST_INSTRS * THREAD_COUNT * 2;
    localparam int LOAD_CYCLES   = 5 * 2 * (I_DEPTH + 16);
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_NS   = (RUN_CYCLES + LOAD_CYCLES + MARGIN_CYCLES) * PERIOD_NS;

    logic                         clock;
    logic                         arst_n;
    logic                         run;
    logic                         host_wren;
    host_sel_e                    host_sel;
    logic [THREAD_ADDR_WIDTH-1:0] host_thread;
    logic [OPERAND_WIDTH-1:0]     host_addr;
    logic [INSTR_WIDTH-1:0]       host_data;
    logic                         result_valid;
    logic [THREAD_ADDR_WIDTH-1:0] result_thread;
    logic [WORD_WIDTH-1:0]        result_data;

    logic [WORD_WIDTH-1:0] results [THREAD_COUNT][$];
    string                 current_test;

    clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) clk_rst (
        .clock  (clock),
        .arst_n (arst_n)
    );

    barrel_core #(
        .WORD_WIDTH        (WORD_WIDTH),
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .I_DEPTH           (I_DEPTH)
    ) barrel_core_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .run           (run),
        .host_wren     (host_wren),
        .host_sel      (host_sel),
        .host_thread   (host_thread),
        .host_addr     (host_addr),
        .host_data     (host_data),
        .result_valid  (result_valid),
        .result_thread (result_thread),
        .result_data   (result_data)
    );

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [INSTR_WIDTH-1:0] encode(input op_e op, input int d,
                                                      input int a, input int b);
        return {op, OPERAND_WIDTH'(d), OPERAND_WIDTH'(a), OPERAND_WIDTH'(b)};
    endfunction

    // the core is stopped, so the result port must stay quiet during every load.
    task automatic host_write(input host_sel_e sel, input int thread, input int addr,
                              input logic [INSTR_WIDTH-1:0] data);
        @(negedge clock);
        check_equal(current_test, 32'd0, 32'(result_valid));
        host_wren   = 1'b1;
        host_sel    = sel;
        host_thread = THREAD_ADDR_WIDTH'(thread);
        host_addr   = OPERAND_WIDTH'(addr);
        host_data   = data;
        @(negedge clock);
        host_wren   = 1'b0;
    endtask

    task automatic load_instr(input int addr, input logic [INSTR_WIDTH-1:0] instr);
        host_write(SEL_INSTR, 0, addr, instr);
    endtask

    task automatic load_reg(input int thread, input int addr, input int value);
        host_write(SEL_REG, thread, addr, INSTR_WIDTH'(value));
    endtask

    // every word becomes a jump to itself, so an idle thread parks in place.
    task automatic park_threads();
        for (int a = 0; a < I_DEPTH; a++) begin
            load_instr(a, encode(OP_JMP, a, 0, 0));
        end
    endtask

    task automatic collect(input logic [THREAD_COUNT-1:0] mask, input int count);
        bit done;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            results[t].delete();
        end
        @(negedge clock);
        run  = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (result_valid) begin
                results[result_thread].push_back(result_data);
            end
            done = 1'b1;
            for (int t = 0; t < THREAD_COUNT; t++) begin
                if (mask[t] && results[t].size() < count) begin
                    done = 1'b0;
                end
            end
        end
        run = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clock);
    endtask

    // each region emits its own register and so exposes a wrong start address.
    task automatic reset_idle();
        int reg_val [THREAD_COUNT][THREAD_COUNT];
        current_test = "reset_idle";
        park_threads();
        for (int t = 0; t < THREAD_COUNT; t++) begin
            for (int r = 0; r < THREAD_COUNT; r++) begin
                // the low bits tag thread and register and keep every word distinct.
                reg_val[t][r] = int'($urandom % 4096) * 16 + t * THREAD_COUNT + r;
                load_reg(t, r + 1, reg_val[t][r]);
            end
            load_instr(t * REGION, encode(OP_OUT, 0, t + 1, 0));
        end
        collect('1, 1);
        for (int t = 0; t < THREAD_COUNT; t++) begin
            check_equal(current_test, 32'(reg_val[t][t]), 32'(results[t][0]));
        end
    endtask

    task automatic alu_ops();
        int a;
        int b;
        current_test = "alu_ops";
        a = int'($urandom % 65536);
        b = int'($urandom % 65536);
        park_threads();
        load_reg(0, 1, a);
        load_reg(0, 2, b);
        load_instr(0, encode(OP_ADD, 3, 1, 2));
        load_instr(1, encode(OP_OUT, 0, 3, 0));
        load_instr(2, encode(OP_SUB, 4, 1, 2));
        load_instr(3, encode(OP_OUT, 0, 4, 0));
        load_instr(4, encode(OP_AND, 5, 1, 2));
        load_instr(5, encode(OP_OUT, 0, 5, 0));
        load_instr(6, encode(OP_XOR, 6, 1, 2));
        load_instr(7, encode(OP_OUT, 0, 6, 0));
        load_instr(8, encode(OP_SHR, 7, 1, 0));
        load_instr(9, encode(OP_OUT, 0, 7, 0));
        collect(THREAD_COUNT'(1), 5);
        check_equal(current_test, 32'((a + b) % 65536), 32'(results[0][0]));
        check_equal(current_test, 32'((a - b + 65536) % 65536), 32'(results[0][1]));
        check_equal(current_test, 32'(a & b), 32'(results[0][2]));
        check_equal(current_test, 32'(a ^ b), 32'(results[0][3]));
        check_equal(current_test, 32'(a / 2), 32'(results[0][4]));
    endtask

    task automatic jump_loop();
        int value;
        int mask_val;
        int base;
        current_test = "jump_loop";
        value    = int'($urandom % 65536);
        mask_val = int'($urandom % 65536) | 1;
        base     = REGION;
        park_threads();
        load_reg(1, 1, value);
        load_reg(1, 2, mask_val);
        load_instr(base, encode(OP_OUT, 0, 1, 0));
        load_instr(base + 1, encode(OP_XOR, 1, 1, 2));
        load_instr(base + 2, encode(OP_JMP, base, 0, 0));
        collect(THREAD_COUNT'(2), 6);
        for (int i = 0; i < 6; i++) begin
            check_equal(current_test, 32'(value), 32'(results[1][i]));
            value = value ^ mask_val;
        end
    endtask

    // counts down to zero, then jz leaves the loop for a final marker.
    task automatic branch_zero();
        int count;
        int marker;
        int base;
        current_test = "branch_zero";
        count  = 2 + int'($urandom % 5);
        marker = int'($urandom % 65536);
        base   = 2 * REGION;
        park_threads();
        load_reg(2, 1, count);
        load_reg(2, 2, 1);
        load_reg(2, 3, marker);
        load_instr(base, encode(OP_OUT, 0, 1, 0));
        load_instr(base + 1, encode(OP_SUB, 1, 1, 2));
        load_instr(base + 2, encode(OP_JZ, base + 4, 1, 0));
        load_instr(base + 3, encode(OP_JMP, base, 0, 0));
        load_instr(base + 4, encode(OP_OUT, 0, 3, 0));
        collect(THREAD_COUNT'(4), count + 1);
        for (int i = 0; i < count; i++) begin
            check_equal(current_test, 32'(count - i), 32'(results[2][i]));
        end
        check_equal(current_test, 32'(marker), 32'(results[2][count]));
    endtask

    task automatic thread_isolation();
        int a [THREAD_COUNT];
        int b [THREAD_COUNT];
        current_test = "thread_isolation";
        park_threads();
        for (int t = 0; t < THREAD_COUNT; t++) begin
            a[t] = int'($urandom % 65536);
            b[t] = int'($urandom % 65536);
            load_reg(t, 1, a[t]);
            load_reg(t, 2, b[t]);
            load_instr(t * REGION, encode(OP_OUT, 0, 1, 0));
            load_instr(t * REGION + 1, encode(OP_ADD, 3, 1, 2));
            load_instr(t * REGION + 2, encode(OP_OUT, 0, 3, 0));
        end
        collect('1, 2);
        for (int t = 0; t < THREAD_COUNT; t++) begin
            check_equal(current_test, 32'(a[t]), 32'(results[t][0]));
            check_equal(current_test, 32'((a[t] + b[t]) % 65536), 32'(results[t][1]));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

    initial begin
        void'($urandom(32'h68d3));
        run          = 1'b0;
        host_wren    = 1'b0;
        host_sel     = SEL_INSTR;
        host_thread  = '0;
        host_addr    = '0;
        host_data    = '0;
        current_test = "startup";
        wait (arst_n === 1'b1);
        reset_idle();
        alu_ops();
        jump_loop();
        branch_zero();
        thread_isolation();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
)
(
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release on a falling edge, away from the sampling edge.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/barrel_core.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_core
    import barrel_pkg::*;
#(
    parameter int WORD_WIDTH        = 16,
    parameter int THREAD_COUNT      = 4,
    parameter int THREAD_ADDR_WIDTH = 2,
    parameter int I_DEPTH           = 64
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,
    input  wire logic                         run,

    input  wire logic                         host_wren,
    input  wire host_sel_e                    host_sel,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] host_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     host_addr,
    input  wire logic [INSTR_WIDTH-1:0]       host_data,

    output logic                              result_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] result_thread,
    output logic      [WORD_WIDTH-1:0]        result_data
);

    logic                         issue_valid;
    logic [THREAD_ADDR_WIDTH-1:0] issue_thread;
    logic [OPERAND_WIDTH-1:0]     issue_pc;

    logic [INSTR_WIDTH-1:0]       instr;
    logic                         instr_valid;
    logic [THREAD_ADDR_WIDTH-1:0] instr_thread;

    logic [OPERAND_WIDTH-1:0]     a_addr;
    logic [OPERAND_WIDTH-1:0]     b_addr;
    logic [THREAD_ADDR_WIDTH-1:0] rd_thread;
    logic [WORD_WIDTH-1:0]        a_data;
    logic [WORD_WIDTH-1:0]        b_data;

    op_e                          op;
    logic [OPERAND_WIDTH-1:0]     d_field;
    logic                         dec_valid;
    logic [THREAD_ADDR_WIDTH-1:0] dec_thread;

    logic                         res_valid;
    logic                         res_wren;
    logic [THREAD_ADDR_WIDTH-1:0] res_thread;
    logic [OPERAND_WIDTH-1:0]     res_addr;
    logic [WORD_WIDTH-1:0]        res_data;
    logic                         out_valid;
    logic [WORD_WIDTH-1:0]        out_data;

    logic                         br_valid;
    logic [THREAD_ADDR_WIDTH-1:0] br_thread;
    logic [OPERAND_WIDTH-1:0]     br_target;

    logic                         wr_en;
    logic [THREAD_ADDR_WIDTH-1:0] wr_thread;
    logic [OPERAND_WIDTH-1:0]     wr_addr;
    logic [WORD_WIDTH-1:0]        wr_data;

    thread_pc #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .I_DEPTH           (I_DEPTH)
    ) pc_ctrl (
        .clock        (clock),
        .arst_n       (arst_n),
        .run          (run),
        .br_valid     (br_valid),
        .br_thread    (br_thread),
        .br_target    (br_target),
        .issue_valid  (issue_valid),
        .issue_thread (issue_thread),
        .issue_pc     (issue_pc)
    );

    // the fetched pc is carried for observation only.
    instr_mem #(
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .I_DEPTH           (I_DEPTH)
    ) i_mem (
        .clock        (clock),
        .arst_n       (arst_n),
        .host_wren    (host_wren),
        .host_sel     (host_sel),
        .host_addr    (host_addr),
        .host_data    (host_data),
        .rd_valid     (issue_valid),
        .rd_thread    (issue_thread),
        .rd_pc        (issue_pc),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_thread (instr_thread),
        .instr_pc     ()
    );

    reg_file #(
        .WORD_WIDTH        (WORD_WIDTH),
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) regs (
        .clock       (clock),
        .host_wren   (host_wren),
        .host_sel    (host_sel),
        .host_thread (host_thread),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .wr_en       (wr_en),
        .wr_thread   (wr_thread),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_thread   (rd_thread),
        .a_addr      (a_addr),
        .b_addr      (b_addr),
        .a_data      (a_data),
        .b_data      (b_data)
    );

    instr_decode #(
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) decode (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_thread (instr_thread),
        .a_addr       (a_addr),
        .b_addr       (b_addr),
        .rd_thread    (rd_thread),
        .op           (op),
        .d_field      (d_field),
        .dec_valid    (dec_valid),
        .dec_thread   (dec_thread)
    );

    alu_execute #(
        .WORD_WIDTH        (WORD_WIDTH),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) execute (
        .clock      (clock),
        .arst_n     (arst_n),
        .op         (op),
        .d_field    (d_field),
        .dec_valid  (dec_valid),
        .dec_thread (dec_thread),
        .a_data     (a_data),
        .b_data     (b_data),
        .res_valid  (res_valid),
        .res_wren   (res_wren),
        .res_thread (res_thread),
        .res_addr   (res_addr),
        .res_data   (res_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .br_valid   (br_valid),
        .br_thread  (br_thread),
        .br_target  (br_target)
    );

    result_write #(
        .WORD_WIDTH        (WORD_WIDTH),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) write_back (
        .clock         (clock),
        .arst_n        (arst_n),
        .res_valid     (res_valid),
        .res_wren      (res_wren),
        .res_thread    (res_thread),
        .res_addr      (res_addr),
        .res_data      (res_data),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .wr_en         (wr_en),
        .wr_thread     (wr_thread),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .result_valid  (result_valid),
        .result_thread (result_thread),
        .result_data   (result_data)
    );

endmodule

`default_nettype wire

// File: verilog/result_write.sv
`timescale 1ns/1ps
`default_nettype none

module result_write
    import barrel_pkg::*;
#(
    parameter int WORD_WIDTH        = 0,
    parameter int THREAD_ADDR_WIDTH = 0
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,

    input  wire logic                         res_valid,
    input  wire logic                         res_wren,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] res_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     res_addr,
    input  wire logic [WORD_WIDTH-1:0]        res_data,
    input  wire logic                         out_valid,
    input  wire logic [WORD_WIDTH-1:0]        out_data,

    output logic                              wr_en,
    output logic      [THREAD_ADDR_WIDTH-1:0] wr_thread,
    output logic      [OPERAND_WIDTH-1:0]     wr_addr,
    output logic      [WORD_WIDTH-1:0]        wr_data,

    output logic                              result_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] result_thread,
    output logic      [WORD_WIDTH-1:0]        result_data
);

    // strobes drop whenever no instruction occupies the slot.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_en        <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            wr_en        <= res_valid && res_wren;
            result_valid <= res_valid && out_valid;
        end
    end

    always_ff @(posedge clock) begin
        wr_thread     <= res_thread;
        wr_addr       <= res_addr;
        wr_data       <= res_data;
        result_thread <= res_thread;
        result_data   <= out_data;
    end

endmodule

`default_nettype wire

// File: verilog/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute
    import barrel_pkg::*;
#(
    parameter int WORD_WIDTH        = 0,
    parameter int THREAD_ADDR_WIDTH = 0
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,

    input  wire op_e                          op,
    input  wire logic [OPERAND_WIDTH-1:0]     d_field,
    input  wire logic                         dec_valid,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] dec_thread,
    input  wire logic [WORD_WIDTH-1:0]        a_data,
    input  wire logic [WORD_WIDTH-1:0]        b_data,

    output logic                              res_valid,
    output logic                              res_wren,
    output logic      [THREAD_ADDR_WIDTH-1:0] res_thread,
    output logic      [OPERAND_WIDTH-1:0]     res_addr,
    output logic      [WORD_WIDTH-1:0]        res_data,
    output logic                              out_valid,
    output logic      [WORD_WIDTH-1:0]        out_data,

    output logic                              br_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] br_thread,
    output logic      [OPERAND_WIDTH-1:0]     br_target
);

    logic [WORD_WIDTH-1:0] alu;
    logic                  alu_op;
    logic                  take;

    always_comb begin
        alu    = '0;
        alu_op = 1'b0;
        take   = 1'b0;
        case (op)
            OP_ADD: begin
                alu    = a_data + b_data;
                alu_op = 1'b1;
            end
            OP_SUB: begin
                alu    = a_data - b_data;
                alu_op = 1'b1;
            end
            OP_AND: begin
                alu    = a_data & b_data;
                alu_op = 1'b1;
            end
            OP_XOR: begin
                alu    = a_data ^ b_data;
                alu_op = 1'b1;
            end
            OP_SHR: begin
                alu    = a_data >> 1;
                alu_op = 1'b1;
            end
            OP_JMP: take = 1'b1;
            OP_JZ:  take = (a_data == '0);
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            res_wren  <= 1'b0;
            out_valid <= 1'b0;
            br_valid  <= 1'b0;
        end else begin
            res_valid <= dec_valid;
            res_wren  <= dec_valid && alu_op;
            out_valid <= dec_valid && (op == OP_OUT);
            br_valid  <= dec_valid && take;
        end
    end

    // D is both the destination register and the jump target.
    always_ff @(posedge clock) begin
        res_thread <= dec_thread;
        res_addr   <= d_field;
        res_data   <= alu;
        out_data   <= a_data;
        br_thread  <= dec_thread;
        br_target  <= d_field;
    end

endmodule

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import barrel_pkg::*;
#(
    parameter int THREAD_ADDR_WIDTH = 0
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,

    input  wire logic [INSTR_WIDTH-1:0]       instr,
    input  wire logic                         instr_valid,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] instr_thread,

    output logic      [OPERAND_WIDTH-1:0]     a_addr,
    output logic      [OPERAND_WIDTH-1:0]     b_addr,
    output logic      [THREAD_ADDR_WIDTH-1:0] rd_thread,

    output op_e                               op,
    output logic      [OPERAND_WIDTH-1:0]     d_field,
    output logic                              dec_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] dec_thread
);

    // register reads start now so the data lines up with the registered fields.
    assign a_addr    = instr[A_LSB +: OPERAND_WIDTH];
    assign b_addr    = instr[B_LSB +: OPERAND_WIDTH];
    assign rd_thread = instr_thread;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op        <= OP_NOP;
            dec_valid <= 1'b0;
        end else begin
            op        <= op_e'(instr[OP_LSB +: OPCODE_WIDTH]);
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        d_field    <= instr[D_LSB +: OPERAND_WIDTH];
        dec_thread <= instr_thread;
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import barrel_pkg::*;
#(
    parameter int WORD_WIDTH        = 0,
    parameter int THREAD_COUNT      = 0,
    parameter int THREAD_ADDR_WIDTH = 0
)
(
    input  wire logic                         clock,

    input  wire logic                         host_wren,
    input  wire host_sel_e                    host_sel,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] host_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     host_addr,
    input  wire logic [INSTR_WIDTH-1:0]       host_data,

    input  wire logic                         wr_en,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] wr_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     wr_addr,
    input  wire logic [WORD_WIDTH-1:0]        wr_data,

    input  wire logic [THREAD_ADDR_WIDTH-1:0] rd_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     a_addr,
    input  wire logic [OPERAND_WIDTH-1:0]     b_addr,

    output logic      [WORD_WIDTH-1:0]        a_data,
    output logic      [WORD_WIDTH-1:0]        b_data
);

    localparam int REG_DEPTH = THREAD_COUNT * (2 ** OPERAND_WIDTH);

    logic [WORD_WIDTH-1:0] mem [REG_DEPTH];

    logic                                       host_we;
    logic                                       we;
    logic [THREAD_ADDR_WIDTH+OPERAND_WIDTH-1:0] waddr;
    logic [WORD_WIDTH-1:0]                      wdata;

    // each thread owns a contiguous bank of registers.
    assign host_we = host_wren && (host_sel == SEL_REG);
    assign we      = host_we || wr_en;
    assign waddr   = host_we ? {host_thread, host_addr} : {wr_thread, wr_addr};
    assign wdata   = host_we ? host_data[WORD_WIDTH-1:0] : wr_data;

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        a_data <= mem[{rd_thread, a_addr}];
        b_data <= mem[{rd_thread, b_addr}];
    end

    // write-back comes from a running core, which rules out host loads.
    assert property (@(posedge clock) !(host_we && wr_en));

endmodule

`default_nettype wire

// File: verilog/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import barrel_pkg::*;
#(
    parameter int THREAD_ADDR_WIDTH = 0,
    parameter int I_DEPTH           = 0
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,

    input  wire logic                         host_wren,
    input  wire host_sel_e                    host_sel,
    input  wire logic [OPERAND_WIDTH-1:0]     host_addr,
    input  wire logic [INSTR_WIDTH-1:0]       host_data,

    input  wire logic                         rd_valid,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] rd_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     rd_pc,

    output logic      [INSTR_WIDTH-1:0]       instr,
    output logic                              instr_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] instr_thread,
    output logic      [OPERAND_WIDTH-1:0]     instr_pc
);

    logic [INSTR_WIDTH-1:0] mem [I_DEPTH];

    always_ff @(posedge clock) begin
        if (host_wren && host_sel == SEL_INSTR) begin
            mem[host_addr] <= host_data;
        end
        instr        <= mem[rd_pc];
        instr_thread <= rd_thread;
        instr_pc     <= rd_pc;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= rd_valid;
        end
    end

    // the pc must address every word.
    initial assert (I_DEPTH == 2 ** OPERAND_WIDTH);

    // host loads happen only while the core is stopped.
    assert property (@(posedge clock) disable iff (!arst_n)
        host_wren |-> !rd_valid && !instr_valid);

endmodule

`default_nettype wire

// File: verilog/thread_pc.sv
`timescale 1ns/1ps
`default_nettype none

module thread_pc
    import barrel_pkg::*;
#(
    parameter int THREAD_COUNT      = 0,
    parameter int THREAD_ADDR_WIDTH = 0,
    parameter int I_DEPTH           = 0
)
(
    input  wire logic                         clock,
    input  wire logic                         arst_n,
    input  wire logic                         run,

    input  wire logic                         br_valid,
    input  wire logic [THREAD_ADDR_WIDTH-1:0] br_thread,
    input  wire logic [OPERAND_WIDTH-1:0]     br_target,

    output logic                              issue_valid,
    output logic      [THREAD_ADDR_WIDTH-1:0] issue_thread,
    output logic      [OPERAND_WIDTH-1:0]     issue_pc
);

    localparam int REGION = I_DEPTH / THREAD_COUNT;
    localparam logic [THREAD_ADDR_WIDTH-1:0] LAST_THREAD = THREAD_ADDR_WIDTH'(THREAD_COUNT - 1);

    logic [OPERAND_WIDTH-1:0]     pc [THREAD_COUNT];
    logic [THREAD_ADDR_WIDTH-1:0] ptr;
    logic                         redirect;
    logic [OPERAND_WIDTH-1:0]     fetch_pc;

    // a branch resolved for the thread that issues now wins over its stored pc.
    assign redirect = br_valid && (br_thread == ptr);
    assign fetch_pc = redirect ? br_target : pc[ptr];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ptr         <= '0;
            issue_valid <= 1'b0;
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc[t] <= OPERAND_WIDTH'(t * REGION);
            end
        end else if (!run) begin
            ptr         <= '0;
            issue_valid <= 1'b0;
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc[t] <= OPERAND_WIDTH'(t * REGION);
            end
        end else begin
            issue_valid <= 1'b1;
            pc[ptr]     <= fetch_pc + 1'b1;
            ptr         <= (ptr == LAST_THREAD) ? '0 : ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        issue_thread <= ptr;
        issue_pc     <= fetch_pc;
    end

    // execute is exactly one round behind issue, so a branch always meets its own thread.
    assert property (@(posedge clock) disable iff (!arst_n)
        run && br_valid |-> br_thread == ptr);

endmodule

`default_nettype wire

// File: verilog/barrel_pkg.sv
`default_nettype none

package barrel_pkg;

    localparam int OPCODE_WIDTH  = 4;
    localparam int OPERAND_WIDTH = 6;
    localparam int INSTR_WIDTH   = OPCODE_WIDTH + 3 * OPERAND_WIDTH;

    // instruction layout is op, D, A, B from msb down.
    localparam int OP_LSB = 3 * OPERAND_WIDTH;
    localparam int D_LSB  = 2 * OPERAND_WIDTH;
    localparam int A_LSB  = OPERAND_WIDTH;
    localparam int B_LSB  = 0;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_XOR = 4'd4,
        OP_SHR = 4'd5,
        OP_JMP = 4'd6,
        OP_JZ  = 4'd7,
        OP_OUT = 4'd8
    } op_e;

    // target of a host write.
    typedef enum logic {
        SEL_INSTR = 1'b0,
        SEL_REG   = 1'b1
    } host_sel_e;

endpackage

`default_nettype wire
